/* Makefile */
SIM      ?= verilator
TOP      ?= perfMonitorTb
FILELIST ?= build.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log
VFLAGS   ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
perfPkg.sv
coprocIf.sv
eventRouter.sv
eventCounter.sv
counterReadout.sv
perfMonitor.sv
perfMonitorTb.sv

/* coprocIf.sv */
`timescale 1ns/1ps

module coprocIf (
  input  logic                            SYSCLK,
  input  logic                            rstN,
  input  logic [31:0]                     instIf,
  input  logic                            iStallIf,
  input  logic                            iMiss,
  input  logic                            dMiss,
  input  logic                            iVal,
  input  logic                            dVal,
  input  logic [perfPkg::HALT_WIDTH-1:0]  haltVec,
  output logic                            dLoad,
  output logic                            rHold,
  output logic [31:0]                     instSf,
  output logic [perfPkg::NUM_EVENTS-1:0]  events
);

  localparam logic [3:0] ST_RESET     = 4'b0001;
  localparam logic [3:0] ST_LOAD      = 4'b0010;
  localparam logic [3:0] ST_REQUEST   = 4'b0100;
  localparam logic [3:0] ST_FIRSTBEAT = 4'b1000;

  logic [3:0]        iState;
  logic [3:0]        iStateNext;
  logic [3:0]        dState;
  logic [3:0]        dStateNext;
  logic [31:0]       instNext;
  perfPkg::instrWord instSfR;
  logic              isLoad;
  logic              isStore;
  logic              issue;

  assign rHold  = |haltVec;
  assign instSf = instSfR.raw;
  assign issue  = ~(rHold | iStallIf);

  always_comb begin
    iStateNext = ST_LOAD;
    instNext   = instIf;
    case (iState)
      ST_RESET:
        instNext = rHold ? perfPkg::INSTR_NOP : instIf;
      ST_LOAD:
        if (iMiss) begin
          iStateNext = ST_REQUEST;
          instNext   = instSfR.raw;  // Hold until refill.
        end else if (rHold) begin
          instNext = instSfR.raw;
        end
      ST_REQUEST:
        if (iVal) begin
          iStateNext = ST_FIRSTBEAT;
        end else begin
          iStateNext = ST_REQUEST;
          instNext   = instSfR.raw;
        end
      ST_FIRSTBEAT:
        if (rHold) begin
          iStateNext = ST_FIRSTBEAT;
          instNext   = instSfR.raw;
        end
      default: ;
    endcase
    // fetch stall without a pipeline hold injects a bubble
    if (iStallIf && !rHold) begin
      iStateNext = ST_LOAD;
      instNext   = '0;
    end
  end

  always_comb begin
    dStateNext = ST_LOAD;
    dLoad      = 1'b0;
    case (dState)
      ST_LOAD:
        if (dMiss) dStateNext = ST_REQUEST;
      ST_REQUEST: begin
        dLoad      = 1'b1;  // Request to the data cache.
        dStateNext = dVal ? ST_FIRSTBEAT : ST_REQUEST;
      end
      ST_FIRSTBEAT:
        if (rHold) dStateNext = ST_FIRSTBEAT;
      default: ;
    endcase
  end

  always_comb begin
    isLoad  = 1'b0;
    isStore = 1'b0;
    case (instSfR.iType.opcode)
      perfPkg::OP_LB, perfPkg::OP_LBU,
      perfPkg::OP_LH, perfPkg::OP_LHU,
      perfPkg::OP_LW: isLoad = 1'b1;
      perfPkg::OP_SB, perfPkg::OP_SH,
      perfPkg::OP_SW: isStore = 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge SYSCLK) begin
    if (!rstN) begin
      instSfR.raw <= perfPkg::INSTR_NOP;
      iState      <= ST_RESET;
      dState      <= ST_RESET;
    end else begin
      instSfR.raw <= instNext;
      iState      <= iStateNext;
      dState      <= dStateNext;
    end
  end

  always_ff @(posedge SYSCLK) begin
    if (!rstN) begin
      events <= '0;
    end else begin
      events[perfPkg::EV_INST]   <= issue;
      events[perfPkg::EV_IMISS]  <= iMiss;
      events[perfPkg::EV_ISTALL] <= haltVec[perfPkg::HALT_IC_S] | haltVec[perfPkg::HALT_IW_S];
      events[perfPkg::EV_DMISS]  <= dMiss;
      events[perfPkg::EV_DSTALL] <= haltVec[perfPkg::HALT_DC_W] | haltVec[perfPkg::HALT_DC_M] |
                                    haltVec[perfPkg::HALT_DW_W] | haltVec[perfPkg::HALT_CBUS_W];
      events[perfPkg::EV_DLOAD]  <= isLoad & issue;
      events[perfPkg::EV_DSTORE] <= isStore & issue;
    end
  end

  aStateOneHot: assert property (@(posedge SYSCLK) disable iff (!rstN)
    $onehot(iState) && $onehot(dState))
    else $error("coprocIf state register not one-hot");

  aDLoadInRequest: assert property (@(posedge SYSCLK) disable iff (!rstN)
    dLoad |-> $past(dMiss) || ($past(dLoad) && !$past(dVal)))
    else $error("dLoad high without a pending data miss");

endmodule

/* counterReadout.sv */
`timescale 1ns/1ps

module counterReadout #(
  parameter int NUM_COUNTERS = 4,
  parameter int COUNT_WIDTH  = 32
) (
  input  logic                                SYSCLK,
  input  logic                                rstN,
  input  logic [$clog2(NUM_COUNTERS):0]       rdAddr,
  input  logic [NUM_COUNTERS*COUNT_WIDTH-1:0] countBus,
  output logic [COUNT_WIDTH-1:0]              rdData
);

  logic [COUNT_WIDTH-1:0] rdNext;

  always_comb begin
    rdNext = '0;  // Out of range reads zero.
    for (int i = 0; i < NUM_COUNTERS; i++) begin
      if (rdAddr == i) rdNext = countBus[i*COUNT_WIDTH +: COUNT_WIDTH];
    end
  end

  always_ff @(posedge SYSCLK) begin
    if (!rstN) begin
      rdData <= '0;
    end else begin
      rdData <= rdNext;
    end
  end

  aRdAddrKnown: assert property (@(posedge SYSCLK) disable iff (!rstN)
    !$isunknown(rdAddr))
    else $error("rdAddr has unknown bits");

endmodule

/* eventCounter.sv */
`timescale 1ns/1ps

module eventCounter #(
  parameter int COUNT_WIDTH = 32
) (
  input  logic                   SYSCLK,
  input  logic                   rstN,
  input  logic                   clr,
  input  logic                   inc,
  output logic [COUNT_WIDTH-1:0] count
);

  always_ff @(posedge SYSCLK) begin
    if (!rstN) begin
      count <= '0;
    end else if (clr) begin
      count <= '0;  // Clear beats increment.
    end else if (inc) begin
      count <= count + 1'b1;  // Wraps.
    end
  end

  aClearZero: assert property (@(posedge SYSCLK) disable iff (!rstN)
    clr |=> count == '0)
    else $error("count not zero after clear");

endmodule

/* eventRouter.sv */
`timescale 1ns/1ps

module eventRouter #(
  parameter int NUM_COUNTERS = 4
) (
  input  logic                            SYSCLK,
  input  logic                            rstN,
  input  logic                            cfgWr,
  input  logic [$clog2(NUM_COUNTERS):0]   cfgAddr,
  input  logic [2:0]                      cfgSel,
  input  logic [perfPkg::NUM_EVENTS-1:0]  events,
  output logic [NUM_COUNTERS-1:0]         cntInc
);

  logic [2:0] selR [NUM_COUNTERS];

  always_ff @(posedge SYSCLK) begin
    if (!rstN) begin
      for (int i = 0; i < NUM_COUNTERS; i++) begin
        selR[i] <= '0;
      end
    end else if (cfgWr) begin
      for (int i = 0; i < NUM_COUNTERS; i++) begin
        if (cfgAddr == i) selR[i] <= cfgSel;
      end
    end
  end

  // Select 7 routes nothing.
  always_comb begin
    for (int i = 0; i < NUM_COUNTERS; i++) begin
      if (selR[i] < perfPkg::NUM_EVENTS) begin
        cntInc[i] = events[selR[i]];
      end else begin
        cntInc[i] = 1'b0;
      end
    end
  end

  aCfgAddrRange: assert property (@(posedge SYSCLK) disable iff (!rstN)
    cfgWr |-> cfgAddr < NUM_COUNTERS)
    else $error("cfgWr to counter %0d out of range", cfgAddr);

endmodule

/* perfMonitor.sv */
`timescale 1ns/1ps

module perfMonitor #(
  parameter int NUM_COUNTERS = 4,
  parameter int COUNT_WIDTH  = 32
) (
  input  logic                            SYSCLK,
  input  logic                            rstN,
  input  logic [31:0]                     instIf,
  input  logic                            iStallIf,
  input  logic                            iMiss,
  input  logic                            dMiss,
  input  logic                            iVal,
  input  logic                            dVal,
  input  logic [perfPkg::HALT_WIDTH-1:0]  haltVec,
  input  logic                            cfgWr,
  input  logic [$clog2(NUM_COUNTERS):0]   cfgAddr,
  input  logic [2:0]                      cfgSel,
  input  logic [NUM_COUNTERS-1:0]         cntClr,
  input  logic [$clog2(NUM_COUNTERS):0]   rdAddr,
  output logic                            dLoad,
  output logic                            rHold,
  output logic [31:0]                     instSf,
  output logic [COUNT_WIDTH-1:0]          rdData
);

  logic [perfPkg::NUM_EVENTS-1:0]    events;
  logic [NUM_COUNTERS-1:0]           cntInc;
  logic [NUM_COUNTERS*COUNT_WIDTH-1:0] countBus;

  coprocIf uCoprocIf (
    .SYSCLK(SYSCLK), .rstN(rstN), .instIf(instIf), .iStallIf(iStallIf),
    .iMiss(iMiss), .dMiss(dMiss), .iVal(iVal), .dVal(dVal), .haltVec(haltVec),
    .dLoad(dLoad), .rHold(rHold), .instSf(instSf), .events(events)
  );

  eventRouter #(.NUM_COUNTERS(NUM_COUNTERS)) uEventRouter (
    .SYSCLK(SYSCLK), .rstN(rstN), .cfgWr(cfgWr), .cfgAddr(cfgAddr),
    .cfgSel(cfgSel), .events(events), .cntInc(cntInc)
  );

  for (genvar g = 0; g < NUM_COUNTERS; g++) begin : gCounter
    eventCounter #(.COUNT_WIDTH(COUNT_WIDTH)) uEventCounter (
      .SYSCLK(SYSCLK), .rstN(rstN), .clr(cntClr[g]), .inc(cntInc[g]),
      .count(countBus[g*COUNT_WIDTH +: COUNT_WIDTH])
    );
  end

  counterReadout #(
    .NUM_COUNTERS(NUM_COUNTERS),
    .COUNT_WIDTH(COUNT_WIDTH)
  ) uCounterReadout (
    .SYSCLK(SYSCLK), .rstN(rstN), .rdAddr(rdAddr),
    .countBus(countBus), .rdData(rdData)
  );

endmodule

/* perfMonitorTb.sv */
`timescale 1ns/1ps

module perfMonitorTb;

  localparam int NUM_COUNTERS = 4;
  localparam int COUNT_WIDTH  = 32;
  localparam int AW           = $clog2(NUM_COUNTERS) + 1;
  localparam int CLK_PERIOD   = 4;
  localparam int RUN_CYCLES   = 40 + 230 + 90 + 80 + 80 + 200;  // Phase lengths summed.
  localparam logic [5:0] LS_OPS [8] = '{perfPkg::OP_LB, perfPkg::OP_LH, perfPkg::OP_LW,
    perfPkg::OP_LBU, perfPkg::OP_LHU, perfPkg::OP_SB, perfPkg::OP_SH, perfPkg::OP_SW};

  logic                           SYSCLK = 1'b0;
  logic                           rstN;
  logic [31:0]                    instIf;
  logic                           iStallIf;
  logic                           iMiss;
  logic                           dMiss;
  logic                           iVal;
  logic                           dVal;
  logic [perfPkg::HALT_WIDTH-1:0] haltVec;
  logic                           cfgWr;
  logic [AW-1:0]                  cfgAddr;
  logic [2:0]                     cfgSel;
  logic [NUM_COUNTERS-1:0]        cntClr;
  logic [AW-1:0]                  rdAddr;
  logic                           dLoad;
  logic                           rHold;
  logic [31:0]                    instSf;
  logic [COUNT_WIDTH-1:0]         rdData;
  logic [31:0]                    rngState = 32'hc70e8afb;
  int                             valueErrors = 0;
  int                             assertErrors = 0;

  always #(CLK_PERIOD / 2) SYSCLK = ~SYSCLK;

  perfMonitor #(.NUM_COUNTERS(NUM_COUNTERS), .COUNT_WIDTH(COUNT_WIDTH)) UUT (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic nextRandom(output logic [31:0] r);
    rngState = xorshift32(rngState);
    r = rngState;
  endtask

  function automatic bit isLoadOp(input logic [5:0] op);
    return op == perfPkg::OP_LB || op == perfPkg::OP_LH || op == perfPkg::OP_LW ||
           op == perfPkg::OP_LBU || op == perfPkg::OP_LHU;
  endfunction

  function automatic bit isStoreOp(input logic [5:0] op);
    return op == perfPkg::OP_SB || op == perfPkg::OP_SH || op == perfPkg::OP_SW;
  endfunction

  task automatic checkValue(input logic [31:0] got, input logic [31:0] expected,
                            input string what);
    aValue: assert (got == expected)
      else begin
        valueErrors++;
        $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, what, got, expected);
      end
  endtask

  // Quiet pipeline with a fetch stall, so no event fires.
  task automatic goIdle();
    @(posedge SYSCLK);
    instIf   <= perfPkg::INSTR_NOP;
    iStallIf <= 1'b1;
    iMiss    <= 1'b0;
    iVal     <= 1'b0;
    haltVec  <= '0;
    repeat (3) @(posedge SYSCLK);
  endtask

  task automatic writeSelect(input int addr, input int sel);
    @(posedge SYSCLK);
    cfgWr   <= 1'b1;
    cfgAddr <= addr[AW-1:0];
    cfgSel  <= sel[2:0];
    @(posedge SYSCLK);
    cfgWr <= 1'b0;
  endtask

  task automatic readCounter(input int addr, input logic [31:0] expected);
    @(posedge SYSCLK);
    rdAddr <= addr[AW-1:0];
    @(posedge SYSCLK);
    @(negedge SYSCLK);
    checkValue(rdData, expected, $sformatf("rdData of counter %0d", addr));
  endtask

  task automatic dataMiss(input int waitCycles);
    @(posedge SYSCLK);
    dMiss <= 1'b1;
    @(posedge SYSCLK);
    dMiss <= 1'b0;
    repeat (waitCycles) @(posedge SYSCLK);
    dVal <= 1'b1;
    @(posedge SYSCLK);
    dVal <= 1'b0;
    @(posedge SYSCLK);  // Back to load state.
  endtask

  task automatic instMiss(input int waitCycles);
    logic [31:0] r;
    logic [31:0] held;
    nextRandom(r);
    held = r | 32'h1;
    @(posedge SYSCLK);
    instIf   <= held;
    iStallIf <= 1'b0;
    @(posedge SYSCLK);
    iMiss  <= 1'b1;
    instIf <= ~held;
    @(posedge SYSCLK);
    iMiss <= 1'b0;
    repeat (waitCycles) begin
      nextRandom(r);
      instIf <= r;
      @(negedge SYSCLK);
      checkValue(instSf, held, "instSf during fetch miss");
      @(posedge SYSCLK);
    end
    nextRandom(r);
    instIf <= r;
    iVal   <= 1'b1;
    @(posedge SYSCLK);
    iVal <= 1'b0;
    @(negedge SYSCLK);
    checkValue(instSf, r, "instSf after refill");
  endtask

  aHoldLevel: assert property (@(posedge SYSCLK) disable iff (!rstN) rHold == (|haltVec))
    else begin
      assertErrors++;
      $display("CHECK FAILED at %0t: rHold does not follow haltVec", $time);
    end

  aBubble: assert property (@(posedge SYSCLK) disable iff (!rstN)
    iStallIf && !rHold |=> instSf == 32'h0)
    else begin
      assertErrors++;
      $display("CHECK FAILED at %0t: fetch stall gave no zero bubble", $time);
    end

  aDLoadStart: assert property (@(posedge SYSCLK) disable iff (!rstN) dMiss && !dLoad |=> dLoad)
    else begin
      assertErrors++;
      $display("CHECK FAILED at %0t: dLoad not raised after dMiss", $time);
    end

  aDLoadWait: assert property (@(posedge SYSCLK) disable iff (!rstN) dLoad && !dVal |=> dLoad)
    else begin
      assertErrors++;
      $display("CHECK FAILED at %0t: dLoad dropped before dVal", $time);
    end

  aDLoadEnd: assert property (@(posedge SYSCLK) disable iff (!rstN) dLoad && dVal |=> !dLoad)
    else begin
      assertErrors++;
      $display("CHECK FAILED at %0t: dLoad still high after dVal", $time);
    end

  aDLoadCause: assert property (@(posedge SYSCLK) disable iff (!rstN)
    $rose(dLoad) |-> $past(dMiss))
    else begin
      assertErrors++;
      $display("CHECK FAILED at %0t: dLoad rose without dMiss", $time);
    end

  initial begin
    #(2 * RUN_CYCLES * CLK_PERIOD);
    $display("Watchdog expired: the run did not finish in time");
    $display("TB FAILED");
    $finish;
  end

  initial begin
    logic [31:0] r;
    logic [31:0] r2;
    logic [5:0]  h;
    logic [5:0]  op;
    int          expInst;
    int          expLoad;
    int          expStore;
    int          expIStall;
    int          expDStall;
    int          expIMiss;
    expInst   = 0;
    expLoad   = 0;
    expStore  = 0;
    expIStall = 0;
    expDStall = 0;
    expIMiss  = 0;
    rstN     <= 1'b0;
    instIf   <= perfPkg::INSTR_NOP;
    iStallIf <= 1'b1;
    iMiss    <= 1'b0;
    dMiss    <= 1'b0;
    iVal     <= 1'b0;
    dVal     <= 1'b0;
    haltVec  <= '0;
    cfgWr    <= 1'b0;
    cfgAddr  <= '0;
    cfgSel   <= '0;
    cntClr   <= '0;
    rdAddr   <= '0;
    repeat (5) @(posedge SYSCLK);
    rstN <= 1'b1;
    @(negedge SYSCLK);
    checkValue({31'b0, dLoad}, 32'h0, "dLoad after reset");
    checkValue(instSf, perfPkg::INSTR_NOP, "instSf after reset");
    for (int a = 0; a <= NUM_COUNTERS; a++) readCounter(a, 0);

    writeSelect(0, perfPkg::EV_INST);
    writeSelect(1, perfPkg::EV_DLOAD);
    writeSelect(2, perfPkg::EV_DSTORE);
    writeSelect(3, 7);
    repeat (200) begin
      nextRandom(r);
      @(posedge SYSCLK);
      h = (r[1:0] == 2'b00) ? r[13:8] : '0;
      haltVec  <= h;
      iStallIf <= r[4] & r[5];
      if (h == '0 && !(r[4] & r[5])) expInst++;
    end
    goIdle();
    readCounter(0, expInst);
    readCounter(NUM_COUNTERS, 0);  // Out of range while counter 0 holds a count.
    writeSelect(0, 7);  // Counter 0 goes quiet.

    repeat (64) begin
      nextRandom(r);
      nextRandom(r2);
      op = r[0] ? LS_OPS[r[3:1]] : r[31:26];
      @(posedge SYSCLK);
      iStallIf <= 1'b0;
      instIf   <= {op, r2[25:0]};
      if (isLoadOp(op)) expLoad++;
      if (isStoreOp(op)) expStore++;
    end
    @(posedge SYSCLK);
    instIf <= perfPkg::INSTR_NOP;  // Last word still issues.
    goIdle();
    readCounter(1, expLoad);
    readCounter(2, expStore);

    repeat (5) begin
      nextRandom(r);
      dataMiss(int'(r[2:0]));
    end
    repeat (4) begin
      nextRandom(r);
      instMiss(int'(r[2:0]) + 1);
    end
    goIdle();

    writeSelect(0, perfPkg::EV_ISTALL);
    writeSelect(1, perfPkg::EV_DSTALL);
    writeSelect(2, perfPkg::EV_IMISS);
    writeSelect(3, perfPkg::EV_DMISS);
    @(posedge SYSCLK);
    cntClr <= '1;
    @(posedge SYSCLK);
    cntClr <= '0;
    repeat (60) begin
      nextRandom(r);
      @(posedge SYSCLK);
      h = r[5:0] & r[11:6];
      haltVec <= h;
      iMiss   <= r[12] & r[13];
      iVal    <= r[14];
      if (h[perfPkg::HALT_IC_S] || h[perfPkg::HALT_IW_S]) expIStall++;
      if (h[perfPkg::HALT_DC_W] || h[perfPkg::HALT_DC_M] ||
          h[perfPkg::HALT_DW_W] || h[perfPkg::HALT_CBUS_W]) expDStall++;
      if (r[12] & r[13]) expIMiss++;
    end
    goIdle();
    for (int k = 0; k < 3; k++) dataMiss(k + 2);
    goIdle();
    readCounter(0, expIStall);
    readCounter(1, expDStall);
    readCounter(2, expIMiss);
    readCounter(3, 3);

    @(posedge SYSCLK);
    cntClr <= 4'b0001;
    @(posedge SYSCLK);
    cntClr <= '0;
    writeSelect(1, perfPkg::EV_INST);  // Counter 1 now follows issue.
    expInst = 0;
    repeat (30) begin
      nextRandom(r);
      @(posedge SYSCLK);
      h = r[0] ? {r[4:1], 2'b00} : '0;  // Data-side halt bits only.
      haltVec  <= h;
      iStallIf <= 1'b0;
      if (h == '0) expInst++;
    end
    goIdle();
    readCounter(0, 0);
    readCounter(1, expDStall + expInst);
    readCounter(3, 3);

    $display("Errors: %0d value checks, %0d assertions", valueErrors, assertErrors);
    if (valueErrors + assertErrors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* perfPkg.sv */
package perfPkg;

  localparam int NUM_EVENTS = 7;

  // Event pulse positions on the events bus.
  localparam int EV_INST   = 0;
  localparam int EV_IMISS  = 1;
  localparam int EV_ISTALL = 2;
  localparam int EV_DMISS  = 3;
  localparam int EV_DSTALL = 4;
  localparam int EV_DLOAD  = 5;
  localparam int EV_DSTORE = 6;

  localparam int HALT_WIDTH = 6;

  localparam int HALT_IC_S   = 0;  // Icache halt, stage S.
  localparam int HALT_IW_S   = 1;
  localparam int HALT_DC_W   = 2;
  localparam int HALT_DC_M   = 3;
  localparam int HALT_DW_W   = 4;
  localparam int HALT_CBUS_W = 5;  // Coprocessor bus halt.

  localparam logic [5:0] OP_LB  = 6'h20;
  localparam logic [5:0] OP_LH  = 6'h21;
  localparam logic [5:0] OP_LW  = 6'h23;
  localparam logic [5:0] OP_LBU = 6'h24;
  localparam logic [5:0] OP_LHU = 6'h25;
  localparam logic [5:0] OP_SB  = 6'h28;
  localparam logic [5:0] OP_SH  = 6'h29;
  localparam logic [5:0] OP_SW  = 6'h2b;

  localparam logic [31:0] INSTR_NOP = 32'h0000_0000;  // sll r0,r0,0.

  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
    } iType;
  } instrWord;

endpackage
